// ==== hdl/pc_periph_pkg.sv ====
// ---------------------------------------------------------------------
// Shared widths and I/O port constants for the XT chipset glue.
// Port numbers are 16 bits wide. Only A15..A0 take part in I/O decode.
// ---------------------------------------------------------------------
package pc_periph_pkg;

    // Bus widths
    localparam int ADDR_W     = 20;
    localparam int DATA_W     = 8;

    // EMS page mapper
    localparam int EMS_SLOTS  = 4;
    localparam int EMS_PAGE_W = 7;

    // Write data that turns a slot off
    localparam logic [DATA_W-1:0] EMS_PAGE_OFF   = 8'hFF;
    // First data byte that is not a page number
    localparam logic [DATA_W-1:0] EMS_PAGE_LIMIT = 8'h80;

    // Default port bases, overridable at the top level
    localparam logic [15:0] DEF_EMS_PORT = 16'h0260;
    localparam logic [15:0] DEF_LPT_PORT = 16'h0378;

    // NMI mask window, 8 ports from this base
    localparam logic [15:0] NMI_PORT     = 16'h00A0;

    // Chipset view of an I/O port number
    typedef struct packed {
        logic [5:0] high;
        logic [1:0] board;
        logic [2:0] block;
        logic [4:0] offset;
    } io_port_fields_t;

    // One port number, seen raw or split into chipset fields
    typedef union packed {
        logic [15:0]     raw;
        io_port_fields_t chipset;
    } io_port_u;

endpackage

// ==== hdl/io_port_decoder.sv ====
// ---------------------------------------------------------------------
// Combinational I/O decode. Selects are only valid while IOR# or IOW#
// is low and AEN is low. Legacy selects need A9..A8 zero.
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module io_port_decoder
    import pc_periph_pkg::*;
#(
    parameter logic [15:0] ems_port = DEF_EMS_PORT,
    parameter logic [15:0] lpt_port = DEF_LPT_PORT
) (
    input  logic [ADDR_W-1:0] address_i,
    input  logic              address_enable_n_i,
    input  logic              io_read_n_i,
    input  logic              io_write_n_i,
    input  logic              ems_enabled_i,
    input  logic              tandy_video_i,
    output logic              dma_cs_n_o,
    output logic              pic_cs_n_o,
    output logic              pit_cs_n_o,
    output logic              ppi_cs_n_o,
    output logic              dma_page_cs_n_o,
    output logic              ems_sel_o,
    output logic              lpt_sel_o,
    output logic              nmi_sel_o
);

    io_port_u    port;
    logic        io_cycle;
    logic        board_hit;
    logic [4:0]  legacy_sel;

    assign port.raw = address_i[15:0];

    // Any I/O strobe with the CPU owning the bus
    assign io_cycle  = (~io_read_n_i | ~io_write_n_i) & ~address_enable_n_i;
    assign board_hit = io_cycle & (port.chipset.board == 2'b00);

    // One-hot block decode, blocks 5..7 are not used here
    always_comb begin
        legacy_sel = '0;
        if (board_hit) begin
            case (port.chipset.block)
                3'd0:    legacy_sel[0] = 1'b1;
                3'd1:    legacy_sel[1] = 1'b1;
                3'd2:    legacy_sel[2] = 1'b1;
                3'd3:    legacy_sel[3] = 1'b1;
                3'd4:    legacy_sel[4] = 1'b1;
                default: legacy_sel    = '0;
            endcase
        end
    end

    assign dma_cs_n_o      = ~legacy_sel[0];
    assign pic_cs_n_o      = ~legacy_sel[1];
    assign pit_cs_n_o      = ~legacy_sel[2];
    assign ppi_cs_n_o      = ~legacy_sel[3];
    assign dma_page_cs_n_o = ~legacy_sel[4];

    // EMS registers, four ports from the base
    assign ems_sel_o = io_cycle & ems_enabled_i & (port.raw[15:2] == ems_port[15:2]);

    // LPT data port, exact match
    assign lpt_sel_o = io_cycle & (port.raw == lpt_port);

    // NMI mask exists only on Tandy machines
    assign nmi_sel_o = io_cycle & tandy_video_i & (port.raw[15:3] == NMI_PORT[15:3]);

endmodule

// ==== hdl/ems_page_mapper.sv ====
// ---------------------------------------------------------------------
// Four EMS slots written through the EMS port window. A write takes
// two clocks to reach the slot. Bank hits are combinational and only
// valid for memory cycles.
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module ems_page_mapper
    import pc_periph_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic [ADDR_W-1:0]    address_i,
    input  logic [DATA_W-1:0]    data_i,
    input  logic                 io_read_n_i,
    input  logic                 io_write_n_i,
    input  logic                 ems_sel_i,
    input  logic [1:0]           ems_window_i,
    output logic [DATA_W-1:0]    ems_read_data_o,
    output logic [EMS_SLOTS-1:0] bank_hit_o
);

    localparam int SLOT_W = $clog2(EMS_SLOTS);

    logic [EMS_PAGE_W-1:0] slot_page [EMS_SLOTS];
    logic [EMS_SLOTS-1:0]  slot_ena;

    logic                  wr_stb;
    logic [SLOT_W-1:0]     wr_slot;
    logic [EMS_PAGE_W-1:0] wr_page;
    logic                  wr_ena;

    logic                  data_off;
    logic                  data_page;
    logic [SLOT_W-1:0]     rd_slot;
    logic [3:0]            win_base;
    logic                  io_cycle;

    // Write data classes, anything else is ignored
    assign data_off  = (data_i == EMS_PAGE_OFF);
    assign data_page = (data_i < EMS_PAGE_LIMIT);

    // Stage the write, FFh leaves 7Fh in the page field
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_stb <= 1'b0;
        end else begin
            wr_stb <= ems_sel_i & ~io_write_n_i & (data_off | data_page);
        end
    end

    always_ff @(posedge clock) begin
        wr_slot <= address_i[SLOT_W-1:0];
        wr_page <= data_i[EMS_PAGE_W-1:0];
        wr_ena  <= data_page;
    end

    // Commit on the following edge
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            slot_ena <= '0;
            for (int k = 0; k < EMS_SLOTS; k++) begin
                slot_page[k] <= '0;
            end
        end else if (wr_stb) begin
            slot_page[wr_slot] <= wr_page;
            slot_ena[wr_slot]  <= wr_ena;
        end
    end

    // Disabled slots read back as FFh
    assign rd_slot = address_i[SLOT_W-1:0];
    assign ems_read_data_o = slot_ena[rd_slot] ?
                             {{(DATA_W-EMS_PAGE_W){1'b0}}, slot_page[rd_slot]} :
                             EMS_PAGE_OFF;

    // 64K frame at A0000h, C0000h or D0000h
    always_comb begin
        case (ems_window_i)
            2'd0:    win_base = 4'hA;
            2'd1:    win_base = 4'hC;
            default: win_base = 4'hD;
        endcase
    end

    assign io_cycle = ~io_read_n_i | ~io_write_n_i;

    // Each slot covers 16K of the frame
    always_comb begin
        for (int k = 0; k < EMS_SLOTS; k++) begin
            bank_hit_o[k] = ~io_cycle & slot_ena[k] &
                (address_i[ADDR_W-1 -: 4+SLOT_W] == {win_base, SLOT_W'(k)});
        end
    end

endmodule

// ==== hdl/chipset_readback.sv ====
// ---------------------------------------------------------------------
// LPT and NMI mask latches plus the registered read data path.
// Read data appears one clock after the sampled strobe. Memory reads
// are not sourced here.
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module chipset_readback
    import pc_periph_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  logic [DATA_W-1:0] data_i,
    input  logic              io_read_n_i,
    input  logic              io_write_n_i,
    input  logic              memory_read_n_i,
    input  logic              interrupt_acknowledge_n_i,
    input  logic              pic_cs_n_i,
    input  logic              pit_cs_n_i,
    input  logic              ppi_cs_n_i,
    input  logic              ems_sel_i,
    input  logic              lpt_sel_i,
    input  logic              nmi_sel_i,
    input  logic [DATA_W-1:0] pic_data_i,
    input  logic [DATA_W-1:0] pit_data_i,
    input  logic [DATA_W-1:0] ppi_data_i,
    input  logic [DATA_W-1:0] ems_data_i,
    output logic [DATA_W-1:0] data_bus_o,
    output logic              from_chipset_o,
    output logic [DATA_W-1:0] nmi_mask_o
);

    logic [DATA_W-1:0] lpt_data;
    logic [DATA_W-1:0] nmi_mask;
    logic              io_rd;
    logic              io_wr;

    assign io_rd = ~io_read_n_i;
    assign io_wr = ~io_write_n_i;

    // Latches update on the edge that samples the write
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data <= 8'hFF;
            nmi_mask <= 8'hFF;
        end else begin
            if (lpt_sel_i & io_wr) begin
                lpt_data <= data_i;
            end
            if (nmi_sel_i & io_wr) begin
                nmi_mask <= data_i;
            end
        end
    end

    assign nmi_mask_o = nmi_mask;

    // Fixed priority, INTA first. memory_read_n_i is reserved for
    // video RAM sources and takes no part yet
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            from_chipset_o <= 1'b0;
            data_bus_o     <= '0;
        end else begin
            from_chipset_o <= 1'b1;
            if (~interrupt_acknowledge_n_i) begin
                data_bus_o <= pic_data_i;
            end else if (~pic_cs_n_i & io_rd) begin
                data_bus_o <= pic_data_i;
            end else if (~pit_cs_n_i & io_rd) begin
                data_bus_o <= pit_data_i;
            end else if (~ppi_cs_n_i & io_rd) begin
                data_bus_o <= ppi_data_i;
            end else if (ems_sel_i & io_rd) begin
                data_bus_o <= ems_data_i;
            end else if (lpt_sel_i & io_rd) begin
                data_bus_o <= lpt_data;
            end else if (nmi_sel_i & io_rd) begin
                data_bus_o <= nmi_mask;
            end else begin
                from_chipset_o <= 1'b0;
                data_bus_o     <= '0;
            end
        end
    end

endmodule

// ==== hdl/pc_peripherals.sv ====
// ---------------------------------------------------------------------
// XT chipset I/O glue. The 8259, 8253 and 8255 are external; only
// their selects and read data pass through here. Single clock domain.
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module pc_peripherals
    import pc_periph_pkg::*;
#(
    parameter logic [15:0] ems_port = DEF_EMS_PORT,
    parameter logic [15:0] lpt_port = DEF_LPT_PORT
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic [ADDR_W-1:0]    address_i,
    input  logic [DATA_W-1:0]    data_i,
    input  logic                 address_enable_n_i,
    input  logic                 io_read_n_i,
    input  logic                 io_write_n_i,
    input  logic                 memory_read_n_i,
    input  logic                 ems_enabled_i,
    input  logic [1:0]           ems_window_i,
    input  logic                 tandy_video_i,
    input  logic                 interrupt_acknowledge_n_i,
    input  logic [DATA_W-1:0]    pic_data_i,
    input  logic [DATA_W-1:0]    pit_data_i,
    input  logic [DATA_W-1:0]    ppi_data_i,
    output logic                 dma_cs_n_o,
    output logic                 pic_cs_n_o,
    output logic                 pit_cs_n_o,
    output logic                 ppi_cs_n_o,
    output logic                 dma_page_cs_n_o,
    output logic [EMS_SLOTS-1:0] bank_hit_o,
    output logic [DATA_W-1:0]    nmi_mask_o,
    output logic [DATA_W-1:0]    data_bus_o,
    output logic                 from_chipset_o
);

    logic              ems_sel;
    logic              lpt_sel;
    logic              nmi_sel;
    logic [DATA_W-1:0] ems_read_data;

    io_port_decoder #(
        .ems_port (ems_port),
        .lpt_port (lpt_port)
    ) u_io_port_decoder (
        .address_i          (address_i),
        .address_enable_n_i (address_enable_n_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .ems_enabled_i      (ems_enabled_i),
        .tandy_video_i      (tandy_video_i),
        .dma_cs_n_o         (dma_cs_n_o),
        .pic_cs_n_o         (pic_cs_n_o),
        .pit_cs_n_o         (pit_cs_n_o),
        .ppi_cs_n_o         (ppi_cs_n_o),
        .dma_page_cs_n_o    (dma_page_cs_n_o),
        .ems_sel_o          (ems_sel),
        .lpt_sel_o          (lpt_sel),
        .nmi_sel_o          (nmi_sel)
    );

    ems_page_mapper u_ems_page_mapper (
        .clock           (clock),
        .reset           (reset),
        .address_i       (address_i),
        .data_i          (data_i),
        .io_read_n_i     (io_read_n_i),
        .io_write_n_i    (io_write_n_i),
        .ems_sel_i       (ems_sel),
        .ems_window_i    (ems_window_i),
        .ems_read_data_o (ems_read_data),
        .bank_hit_o      (bank_hit_o)
    );

    chipset_readback u_chipset_readback (
        .clock                     (clock),
        .reset                     (reset),
        .data_i                    (data_i),
        .io_read_n_i               (io_read_n_i),
        .io_write_n_i              (io_write_n_i),
        .memory_read_n_i           (memory_read_n_i),
        .interrupt_acknowledge_n_i (interrupt_acknowledge_n_i),
        .pic_cs_n_i                (pic_cs_n_o),
        .pit_cs_n_i                (pit_cs_n_o),
        .ppi_cs_n_i                (ppi_cs_n_o),
        .ems_sel_i                 (ems_sel),
        .lpt_sel_i                 (lpt_sel),
        .nmi_sel_i                 (nmi_sel),
        .pic_data_i                (pic_data_i),
        .pit_data_i                (pit_data_i),
        .ppi_data_i                (ppi_data_i),
        .ems_data_i                (ems_read_data),
        .data_bus_o                (data_bus_o),
        .from_chipset_o            (from_chipset_o),
        .nmi_mask_o                (nmi_mask_o)
    );

endmodule

// ==== verification/pc_peripherals_assert.sv ====
// ---------------------------------------------------------------------
// Bus rules checked on the chipset glue top level. Bound to every
// instance of pc_peripherals. Checks are off while reset is high.
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module pc_peripherals_assert (
    input logic       clock,
    input logic       reset,
    input logic       address_enable_n_i,
    input logic       io_read_n_i,
    input logic       interrupt_acknowledge_n_i,
    input logic [4:0] legacy_cs_n_i,
    input logic [2:0] io_sel_i,
    input logic       from_chipset_i
);

    // DMA owns the bus, no device may answer
    assert property (@(posedge clock) disable iff (reset)
        address_enable_n_i |-> (&legacy_cs_n_i && io_sel_i == 3'b000))
        else $error("chip select active while address enable is high");

    assert property (@(posedge clock) disable iff (reset) $onehot0(~legacy_cs_n_i))
        else $error("more than one legacy chip select is low");

    // Nothing to return without a read or an acknowledge
    assert property (@(posedge clock) disable iff (reset)
        (io_read_n_i && interrupt_acknowledge_n_i) |=> !from_chipset_i)
        else $error("from_chipset_o high after an idle cycle");

endmodule

bind pc_peripherals pc_peripherals_assert u_pc_peripherals_assert (
    .clock                     (clock),
    .reset                     (reset),
    .address_enable_n_i        (address_enable_n_i),
    .io_read_n_i               (io_read_n_i),
    .interrupt_acknowledge_n_i (interrupt_acknowledge_n_i),
    .legacy_cs_n_i             ({dma_page_cs_n_o, ppi_cs_n_o, pit_cs_n_o, pic_cs_n_o,
                                 dma_cs_n_o}),
    .io_sel_i                  ({ems_sel, lpt_sel, nmi_sel}),
    .from_chipset_i            (from_chipset_o)
);

// ==== verification/tb_pc_peripherals.sv ====
// ---------------------------------------------------------------------
// Testbench for the chipset glue with default port bases (260h, 378h).
// External 8259/8253/8255 are modelled as plain data inputs.
// Read data is checked on every falling edge against a reference model.
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module tb_pc_peripherals;

    localparam logic [15:0] EMS_BASE   = 16'h0260;
    localparam logic [15:0] LPT_ADDR   = 16'h0378;
    localparam logic [15:0] NMI_BASE   = 16'h00A0;
    localparam int          MAX_CYCLES = 2000;

    logic        clock = 1'b0;
    logic        reset;
    logic [19:0] address;
    logic [7:0]  data;
    logic        aen_n, io_read_n, io_write_n, memory_read_n;
    logic        ems_enabled, tandy_video, inta_n;
    logic [1:0]  ems_window;
    logic [7:0]  pic_data, pit_data, ppi_data;
    logic        dma_cs_n, pic_cs_n, pit_cs_n, ppi_cs_n, dma_page_cs_n;
    logic [3:0]  bank_hit;
    logic [7:0]  nmi_mask, data_bus;
    logic        from_chipset;

    // Reference state of the slots and latches
    logic [6:0]  ems_page [4];
    logic [3:0]  ems_ena;
    logic [7:0]  lpt_model, nmi_model;

    integer      seed = 32'h558c35e8;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic        check_armed = 1'b0;
    logic [8:0]  exp_result;

    pc_peripherals u_pc_peripherals (
        .clock(clock), .reset(reset), .address_i(address), .data_i(data),
        .address_enable_n_i(aen_n), .io_read_n_i(io_read_n), .io_write_n_i(io_write_n),
        .memory_read_n_i(memory_read_n), .ems_enabled_i(ems_enabled),
        .ems_window_i(ems_window), .tandy_video_i(tandy_video),
        .interrupt_acknowledge_n_i(inta_n), .pic_data_i(pic_data), .pit_data_i(pit_data),
        .ppi_data_i(ppi_data), .dma_cs_n_o(dma_cs_n), .pic_cs_n_o(pic_cs_n),
        .pit_cs_n_o(pit_cs_n), .ppi_cs_n_o(ppi_cs_n), .dma_page_cs_n_o(dma_page_cs_n),
        .bank_hit_o(bank_hit), .nmi_mask_o(nmi_mask), .data_bus_o(data_bus),
        .from_chipset_o(from_chipset)
    );

    initial begin
        forever #4 clock = ~clock;
    end

    function automatic logic [7:0] ems_slot_value(input logic [1:0] slot);
        return ems_ena[slot] ? {1'b0, ems_page[slot]} : 8'hFF;
    endfunction

    // Bit 8 is from_chipset_o, bits 7..0 the data bus
    function automatic logic [8:0] expected_readback(input logic [19:0] addr,
            input logic rd_n, input logic a_n, input logic ack_n);
        logic rd;
        logic board;
        rd    = !rd_n && !a_n;
        board = rd && addr[9:8] == 2'b00;
        if (!ack_n) return {1'b1, pic_data};
        if (board && addr[7:5] == 3'd1) return {1'b1, pic_data};
        if (board && addr[7:5] == 3'd2) return {1'b1, pit_data};
        if (board && addr[7:5] == 3'd3) return {1'b1, ppi_data};
        if (rd && ems_enabled && addr[15:2] == EMS_BASE[15:2]) begin
            return {1'b1, ems_slot_value(addr[1:0])};
        end
        if (rd && addr[15:0] == LPT_ADDR) return {1'b1, lpt_model};
        if (rd && tandy_video && addr[15:3] == NMI_BASE[15:3]) return {1'b1, nmi_model};
        return 9'h000;
    endfunction

    function automatic logic [3:0] expected_bank_hits(input logic [19:0] addr,
            input logic [1:0] win);
        logic [3:0] base;
        logic [3:0] hits;
        base = (win == 2'd0) ? 4'hA : (win == 2'd1) ? 4'hC : 4'hD;
        for (int k = 0; k < 4; k++) begin
            hits[k] = ems_ena[k] && addr[19:14] == {base, 2'(k)};
        end
        return hits;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic apply_write(input logic [15:0] port, input logic [7:0] value);
        if (port == LPT_ADDR) lpt_model = value;
        if (tandy_video && port[15:3] == NMI_BASE[15:3]) nmi_model = value;
        if (ems_enabled && port[15:2] == EMS_BASE[15:2]) begin
            if (value == 8'hFF) begin
                ems_ena[port[1:0]]  = 1'b0;
                ems_page[port[1:0]] = 7'h7F;
            end else if (value < 8'h80) begin
                ems_ena[port[1:0]]  = 1'b1;
                ems_page[port[1:0]] = value[6:0];
            end
        end
    endtask

    task automatic io_write(input logic [15:0] port, input logic [7:0] value);
        @(posedge clock);
        address    <= {4'h0, port};
        data       <= value;
        io_write_n <= 1'b0;
        @(posedge clock);
        io_write_n <= 1'b1;
        apply_write(port, value);
    endtask

    task automatic io_read(input logic [15:0] port);
        @(posedge clock);
        address   <= {4'h0, port};
        io_read_n <= 1'b0;
        @(posedge clock);
        io_read_n <= 1'b1;
    endtask

    task automatic decode_probe(input logic [15:0] port, input logic a_n,
            input logic [4:0] onehot);
        @(posedge clock);
        address   <= {4'h0, port};
        aen_n     <= a_n;
        io_read_n <= 1'b0;
        @(negedge clock);
        check_value("legacy cs_n", {dma_page_cs_n, ppi_cs_n, pit_cs_n, pic_cs_n, dma_cs_n},
                    5'(~onehot));
        @(posedge clock);
        io_read_n <= 1'b1;
        aen_n     <= 1'b0;
    endtask

    task automatic bank_probe(input logic [19:0] addr);
        @(posedge clock);
        address       <= addr;
        memory_read_n <= 1'b0;
        @(negedge clock);
        check_value("bank_hit_o", bank_hit, expected_bank_hits(address, ems_window));
    endtask

    // Predict what the DUT registers on this edge
    always @(posedge clock) begin
        check_armed <= !reset;
        exp_result  <= expected_readback(address, io_read_n, aen_n, inta_n);
    end

    always @(negedge clock) begin
        if (check_armed) begin
            check_value("from_chipset_o", from_chipset, exp_result[8]);
            check_value("data_bus_o", data_bus, exp_result[7:0]);
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [7:0]  value;
        address = '0;
        data = '0;
        aen_n = 1'b0;
        io_read_n = 1'b1;
        io_write_n = 1'b1;
        memory_read_n = 1'b1;
        ems_enabled = 1'b1;
        ems_window = 2'd0;
        tandy_video = 1'b1;
        inta_n = 1'b1;
        pic_data = $random(seed);
        pit_data = $random(seed);
        ppi_data = $random(seed);
        ems_ena = '0;
        for (int s = 0; s < 4; s++) begin
            ems_page[s] = '0;
        end
        lpt_model = 8'hFF;
        nmi_model = 8'hFF;
        reset = 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        // Values after reset
        for (int s = 0; s < 4; s++) begin
            io_read(EMS_BASE + 16'(s));
        end
        io_read(LPT_ADDR);
        io_read(NMI_BASE + 16'h3);
        repeat (2) @(posedge clock);
        @(negedge clock);
        check_value("nmi_mask_o", nmi_mask, 8'hFF);

        // Legacy block sweep, then A8 set and AEN high
        for (int b = 0; b < 5; b++) begin
            decode_probe(16'(b << 5) + 16'h1, 1'b0, 5'(1 << b));
        end
        decode_probe(16'h0120, 1'b0, 5'b00000);
        decode_probe(16'h0040, 1'b1, 5'b00000);

        // Random slot writes, FFh forced about one time in four
        for (int i = 0; i < 100; i++) begin
            r = $random(seed);
            value = (r[9:8] == 2'b00) ? 8'hFF : r[7:0];
            io_write(EMS_BASE + 16'(r[17:16]), value);
            io_read(EMS_BASE + 16'(r[25:24]));
        end
        @(posedge clock);
        ems_enabled <= 1'b0;
        for (int s = 0; s < 4; s++) begin
            io_write(EMS_BASE + 16'(s), 8'(s + 8'h10));
        end
        @(posedge clock);
        ems_enabled <= 1'b1;
        for (int s = 0; s < 4; s++) begin
            io_read(EMS_BASE + 16'(s));
        end

        // Bank hits for every window, slot and frame base
        io_write(EMS_BASE + 16'h0, 8'h05);
        io_write(EMS_BASE + 16'h1, 8'hFF);
        io_write(EMS_BASE + 16'h2, 8'h22);
        io_write(EMS_BASE + 16'h3, 8'h7F);
        repeat (2) @(posedge clock);
        for (int w = 0; w < 4; w++) begin
            ems_window <= 2'(w);
            for (int k = 0; k < 4; k++) begin
                r = $random(seed);
                bank_probe({4'hA, 2'(k), r[13:0]});
                bank_probe({4'hC, 2'(k), r[13:0]});
                bank_probe({4'hD, 2'(k), r[13:0]});
                bank_probe({4'hE, 2'(k), r[13:0]});
            end
        end
        @(posedge clock);
        memory_read_n <= 1'b1;

        // LPT and NMI latches
        r = $random(seed);
        io_write(LPT_ADDR, r[7:0]);
        io_read(LPT_ADDR);
        io_write(NMI_BASE + 16'h3, r[15:8]);
        io_read(NMI_BASE + 16'h5);
        @(negedge clock);
        check_value("nmi_mask_o", nmi_mask, nmi_model);
        @(posedge clock);
        tandy_video <= 1'b0;
        io_write(NMI_BASE + 16'h1, ~nmi_model);
        io_read(NMI_BASE + 16'h1);
        @(posedge clock);
        tandy_video <= 1'b1;
        io_read(NMI_BASE);

        // Read-back priority
        @(posedge clock);
        pic_data <= $random(seed);
        pit_data <= $random(seed);
        ppi_data <= $random(seed);
        io_read(16'h0020);
        io_read(16'h0040);
        io_read(16'h0060);
        io_read(16'h0000);
        @(posedge clock);
        address   <= 20'h00060;
        io_read_n <= 1'b0;
        inta_n    <= 1'b0;
        @(posedge clock);
        io_read_n <= 1'b1;
        inta_n    <= 1'b1;

        repeat (3) @(posedge clock);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hdl/pc_periph_pkg.sv
hdl/io_port_decoder.sv
hdl/ems_page_mapper.sv
hdl/chipset_readback.sv
hdl/pc_peripherals.sv
verification/pc_peripherals_assert.sv
verification/tb_pc_peripherals.sv

// ==== Bender.yml ====
package:
  name: pc_peripherals

sources:
  - hdl/pc_periph_pkg.sv
  - hdl/io_port_decoder.sv
  - hdl/ems_page_mapper.sv
  - hdl/chipset_readback.sv
  - hdl/pc_peripherals.sv
  - target: test
    files:
      - verification/pc_peripherals_assert.sv
      - verification/tb_pc_peripherals.sv
